//--- verilog/norm_params.svh
// Widths and limits for the normalize and round unit
// Shared by the package and the datapath blocks

`ifndef NORM_PARAMS_SVH
`define NORM_PARAMS_SVH

// Field widths
`define NORM_MANT_W       23   // binary32 fraction, also the internal fraction
`define NORM_IN_MANT_W    28   // Hidden bit + 23 fraction + 4 extra
`define NORM_EXP_W        8    // binary32 exponent field
`define NORM_IN_EXP_W     10   // Signed exponent with overflow bit
`define NORM_EXP16_W      5
`define NORM_MANT16_W     10
`define NORM_RES_W        32   // Result word, binary16 is boxed into it

// Bits kept below the 24-bit mantissa
`define NORM_EXT_W        28

// Right shift cap for tiny exponents, past this only sticky matters
`define NORM_RS_MAX       27

// Quiet NaN fraction, top fraction bit set
`define NORM_QNAN_MANT    23'h40_0000

// Register stages in the top level
`define NORM_PIPE_STAGES  2

`endif

//--- verilog/norm_pkg.sv
// Types for the normalize and round unit
// Format and rounding enums plus the packed request and result structs

`default_nettype none

`include "norm_params.svh"

package norm_pkg;

  typedef enum logic
  {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fmt_e;

  // Codes of the divider front end, unused codes truncate
  typedef enum logic [2:0]
  {
    RM_NEAREST  = 3'd0,
    RM_TRUNC    = 3'd1,
    RM_MINUSINF = 3'd2,
    RM_PLUSINF  = 3'd3
  } rm_e;

  // Request from the divide/sqrt datapath
  typedef struct packed
  {
    logic [`NORM_IN_MANT_W-1:0]       mant;      // 1.x or 0.1x plus 4 extra bits
    logic signed [`NORM_IN_EXP_W-1:0] exp;       // Already biased for fmt
    logic                             sign;
    logic                             div_en;
    logic                             sqrt_en;
    logic                             inf_a;
    logic                             inf_b;
    logic                             zero_a;
    logic                             zero_b;
    logic                             nan_a;
    logic                             nan_b;
    logic                             snan;      // One operand is signaling
    fmt_e                             fmt;
    rm_e                              rm;
  } op_in_t;

  // Special operand result
  typedef struct packed
  {
    logic hit;       // Overrides the normal path
    logic sign;
    logic exp_ones;  // Exponent all ones, else zero
    logic mant_nan;  // Quiet NaN fraction, else zero
    logic nv;
    logic dz;
    logic of;
  } special_t;

  typedef struct packed
  {
    logic                       sign;
    logic [`NORM_EXP_W-1:0]     exp;
    logic [`NORM_MANT_W:0]      mant;       // Hidden bit on top
    logic [`NORM_EXT_W-1:0]     round_ext;  // Bits below mant
    logic                       uf;
    logic                       of;
  } norm_t;

  // First pipeline register payload
  typedef struct packed
  {
    norm_t    norm;
    special_t spec;
    fmt_e     fmt;
    rm_e      rm;
  } stage1_t;

  typedef struct packed
  {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  typedef struct packed
  {
    logic [`NORM_RES_W-1:0] word;
    fflags_t                flags;
  } result_t;

endpackage

`default_nettype wire

//--- verilog/special_case_sel.sv
// Special operand selector
// Maps NaN, Inf and zero operand classes to a fixed result and flags

`timescale 1ns/1ps
`default_nettype none

module special_case_sel
(
  input  norm_pkg::op_in_t  req,
  output norm_pkg::special_t spec
);

  logic nan_in;       // Any NaN that reaches the result
  logic div_inf_inf;
  logic sqrt_neg_inf;
  logic div_x_inf;
  logic div_zero_zero;
  logic div_x_zero;
  logic sqrt_neg;

  // Positive quiet NaN
  function automatic norm_pkg::special_t nan_res(input logic nv_f, input logic dz_f);
    nan_res = '{hit: 1'b1, sign: 1'b0, exp_ones: 1'b1, mant_nan: 1'b1,
                nv: nv_f, dz: dz_f, of: 1'b0};
  endfunction

  // Signed infinity
  function automatic norm_pkg::special_t inf_res(input logic sign_f, input logic of_f,
                                                 input logic dz_f);
    inf_res = '{hit: 1'b1, sign: sign_f, exp_ones: 1'b1, mant_nan: 1'b0,
                nv: 1'b0, dz: dz_f, of: of_f};
  endfunction

  // Signed zero, no flags
  function automatic norm_pkg::special_t zero_res(input logic sign_f);
    zero_res = '{hit: 1'b1, sign: sign_f, exp_ones: 1'b0, mant_nan: 1'b0,
                 nv: 1'b0, dz: 1'b0, of: 1'b0};
  endfunction

  assign nan_in        = req.nan_a || (req.nan_b && req.div_en);  // b only matters for div
  assign div_inf_inf   = req.div_en && req.inf_a && req.inf_b;
  assign sqrt_neg_inf  = req.sqrt_en && req.inf_a && req.sign;
  assign div_x_inf     = req.div_en && req.inf_b;
  assign div_zero_zero = req.div_en && req.zero_a && req.zero_b;
  assign div_x_zero    = req.div_en && req.zero_b;
  assign sqrt_neg      = req.sqrt_en && req.sign;

  //////////////////////////////////////////////////
  // Priority chain, first match wins
  //////////////////////////////////////////////////
  always_comb
  begin
    spec = '0;                                       // Pass to the normal path
    if (nan_in)
      spec = nan_res(req.snan, 1'b0);                // NV only for signaling NaN
    else if (div_inf_inf)
      spec = nan_res(1'b1, 1'b0);
    else if (sqrt_neg_inf)
      spec = nan_res(1'b1, 1'b0);
    else if (req.inf_a)
      spec = inf_res(req.sign, 1'b1, 1'b0);          // Inf operand propagates
    else if (div_x_inf)
      spec = zero_res(req.sign);
    else if (div_zero_zero)
      spec = nan_res(1'b1, 1'b1);
    else if (req.zero_a)
      spec = zero_res(req.sign);
    else if (div_x_zero)
      spec = inf_res(req.sign, 1'b0, 1'b1);          // Divide by zero
    else if (sqrt_neg)
      spec = nan_res(1'b1, 1'b0);
  end

  // Exception flags never escape without an override
  always_comb
  begin
    assert final (!(spec.nv || spec.dz) || spec.hit)
      else $error("special_case_sel: flag set without hit");
  end

endmodule

`default_nettype wire

//--- verilog/normalizer.sv
// Mantissa normalizer
// Aligns 1.x and 0.1x inputs, denormalizes tiny exponents, flags overflow

`timescale 1ns/1ps
`default_nettype none

`include "norm_params.svh"

module normalizer
(
  input  norm_pkg::op_in_t req,
  output norm_pkg::norm_t  norm
);

  localparam int IW   = `NORM_IN_MANT_W;
  localparam int EW   = `NORM_IN_EXP_W;
  localparam int MW   = `NORM_MANT_W + 1;           // Kept mantissa with hidden bit
  localparam int XW   = `NORM_EXT_W;
  localparam int VW   = MW + XW;                    // Mantissa plus round extension
  localparam int RS_W = $clog2(`NORM_RS_MAX + 1);

  localparam logic signed [EW-1:0] EMAX32 = EW'((1 << `NORM_EXP_W) - 1);
  localparam logic signed [EW-1:0] EMAX16 = EW'((1 << `NORM_EXP16_W) - 1);

  logic                   lead;      // Integer bit of the input
  logic signed [EW-1:0]   exp_max;
  logic                   is_den;
  logic                   is_of;
  logic [EW-1:0]          rs_raw;
  logic [RS_W-1:0]        rs_amt;
  logic [2*VW-1:0]        rs_full;
  logic [VW-1:0]          rs_vec;
  logic                   rs_lost;   // Bits shifted past the extension
  logic [EW-1:0]          exp_dec;

  assign lead    = req.mant[IW-1];
  assign exp_max = (req.fmt == norm_pkg::FMT_FP16) ? EMAX16 : EMAX32;

  // Tiny: exp <= 0, or exp 1 without the leading 1
  assign is_den = (req.exp <= 0) || ((req.exp == 1) && !lead);

  // 0.1x at the top exponent still fits after the left shift
  assign is_of = (req.exp > exp_max) || ((req.exp == exp_max) && lead);

  //////////////////////////////////////////////////
  // Right shift by 1 - exp for denormals
  //////////////////////////////////////////////////
  assign rs_raw  = EW'(1) - $unsigned(req.exp);
  assign rs_amt  = (rs_raw > EW'(`NORM_RS_MAX)) ? RS_W'(`NORM_RS_MAX) : rs_raw[RS_W-1:0];
  assign rs_full = {req.mant, {(2*VW-IW){1'b0}}} >> rs_amt;
  assign rs_vec  = rs_full[2*VW-1:VW];
  assign rs_lost = |rs_full[VW-1:0];                 // Folded into sticky

  assign exp_dec = req.exp - EW'(1);

  always_comb
  begin
    norm.sign = req.sign;
    norm.uf   = 1'b0;
    norm.of   = 1'b0;
    if (is_den)
    begin
      norm.exp       = '0;
      norm.mant      = rs_vec[VW-1:XW];
      norm.round_ext = {rs_vec[XW-1:1], rs_vec[0] | rs_lost};
      norm.uf        = 1'b1;
    end
    else if (is_of)
    begin
      norm.exp       = '1;                          // Infinity
      norm.mant      = '0;
      norm.round_ext = '0;
      norm.of        = 1'b1;
    end
    else if (lead)
    begin
      norm.exp       = req.exp[`NORM_EXP_W-1:0];   // 1.x keeps the exponent
      norm.mant      = req.mant[IW-1:IW-MW];
      norm.round_ext = {req.mant[IW-MW-1:0], {(XW-(IW-MW)){1'b0}}};
    end
    else
    begin
      norm.exp       = exp_dec[`NORM_EXP_W-1:0];   // 0.1x shifts up one place
      norm.mant      = req.mant[IW-2:IW-MW-1];
      norm.round_ext = {req.mant[IW-MW-2:0], {(XW-(IW-MW)+1){1'b0}}};
    end
  end

endmodule

`default_nettype wire

//--- verilog/rounder.sv
// Rounder
// Rounds at the binary32 or binary16 place and renormalizes on carry out

`timescale 1ns/1ps
`default_nettype none

`include "norm_params.svh"

module rounder
(
  input  norm_pkg::norm_t      norm,
  input  norm_pkg::fmt_e       fmt,
  input  norm_pkg::rm_e        rm,
  output logic [`NORM_EXP_W-1:0]  exp_out,
  output logic [`NORM_MANT_W-1:0] mant_out,
  output logic                    inexact
);

  localparam int MW    = `NORM_MANT_W + 1;
  localparam int XW    = `NORM_EXT_W;
  localparam int EW    = `NORM_EXP_W;
  localparam int LSB16 = `NORM_MANT_W - `NORM_MANT16_W;  // Last kept binary16 bit

  logic [MW-1:0] kept;     // Truncated mantissa
  logic [MW-1:0] inc;      // One unit in the last kept place
  logic [MW:0]   sum;
  logic          lsb;
  logic          g;        // First dropped bit
  logic          r;
  logic          s;        // OR of the rest
  logic          up;
  logic          carry;
  logic          promote;  // Denormal rounded into the smallest normal

  //////////////////////////////////////////////////
  // Bit selection per format
  //////////////////////////////////////////////////
  always_comb
  begin
    if (fmt == norm_pkg::FMT_FP16)
    begin
      kept = {norm.mant[MW-1:LSB16], {LSB16{1'b0}}};
      inc  = MW'(1) << LSB16;
      lsb  = norm.mant[LSB16];
      g    = norm.mant[LSB16-1];
      r    = norm.mant[LSB16-2];
      s    = (|norm.mant[LSB16-3:0]) | (|norm.round_ext);
    end
    else
    begin
      kept = norm.mant;
      inc  = MW'(1);
      lsb  = norm.mant[0];
      g    = norm.round_ext[XW-1];
      r    = norm.round_ext[XW-2];
      s    = |norm.round_ext[XW-3:0];
    end
  end

  always_comb
  begin
    case (rm)
      norm_pkg::RM_NEAREST:  up = g && (r || s || lsb);    // Ties to even
      norm_pkg::RM_TRUNC:    up = 1'b0;
      norm_pkg::RM_PLUSINF:  up = (g || r || s) && !norm.sign;
      norm_pkg::RM_MINUSINF: up = (g || r || s) && norm.sign;
      default:               up = 1'b0;                   // Unused codes truncate
    endcase
  end

  assign sum     = {1'b0, kept} + (up ? {1'b0, inc} : '0);
  assign carry   = sum[MW];                               // 1.111.. + 1 ulp
  assign promote = (norm.exp == '0) && sum[MW-1];

  // Renormalize, hidden bit dropped
  assign mant_out = carry ? sum[MW-1:1] : sum[MW-2:0];
  assign exp_out  = norm.exp + {{(EW-1){1'b0}}, carry | promote};
  assign inexact  = g | r | s;

  // Binary16 result must not carry bits below its place
  always_comb
  begin
    assert final ((fmt != norm_pkg::FMT_FP16) || (mant_out[LSB16-1:0] == '0))
      else $error("rounder: binary16 mantissa has low bits set");
  end

endmodule

`default_nettype wire

//--- verilog/result_packer.sv
// Result packer
// Selects special or rounded fields, packs the format and builds the flags

`timescale 1ns/1ps
`default_nettype none

`include "norm_params.svh"

module result_packer
(
  input  norm_pkg::special_t      spec,
  input  norm_pkg::fmt_e          fmt,
  input  logic                    sign,
  input  logic [`NORM_EXP_W-1:0]  exp,
  input  logic [`NORM_MANT_W-1:0] mant,
  input  logic                    uf,
  input  logic                    of,
  input  logic                    inexact,
  output norm_pkg::result_t       res
);

  localparam int MW  = `NORM_MANT_W;
  localparam int E16 = `NORM_EXP16_W;
  localparam int M16 = `NORM_MANT16_W;
  localparam int BOX = `NORM_RES_W - 1 - E16 - M16;      // NaN box width

  logic                     sel_sign;
  logic [`NORM_EXP_W-1:0]   sel_exp;
  logic [MW-1:0]            sel_mant;
  logic                     rnd_of;                       // Rounded up into Inf

  assign rnd_of = (fmt == norm_pkg::FMT_FP16) ? (exp[E16-1:0] == '1) : (exp == '1);

  always_comb
  begin
    if (spec.hit)
    begin
      sel_sign  = spec.sign;
      sel_exp   = spec.exp_ones ? '1 : '0;
      sel_mant  = spec.mant_nan ? `NORM_QNAN_MANT : '0;
      res.flags = '{nv: spec.nv, dz: spec.dz, of: spec.of, uf: 1'b0, nx: 1'b0};
    end
    else
    begin
      sel_sign  = sign;
      sel_exp   = exp;
      sel_mant  = mant;
      res.flags = '{nv: 1'b0, dz: 1'b0, of: of | rnd_of, uf: uf, nx: inexact};
    end

    // Format packing
    if (fmt == norm_pkg::FMT_FP16)
      res.word = {{BOX{1'b1}}, sel_sign, sel_exp[E16-1:0], sel_mant[MW-1 -: M16]};
    else
      res.word = {sel_sign, sel_exp, sel_mant};
  end

endmodule

`default_nettype wire

//--- verilog/stage_reg.sv
// Pipeline register with a valid tag
// Valid clears on reset, payload loads only with valid

`timescale 1ns/1ps
`default_nettype none

module stage_reg
#(
  parameter type payload_t = logic
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_in,
  input  payload_t data_in,
  output logic     valid_out,
  output payload_t data_out
);

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_out <= 1'b0;
    else
      valid_out <= valid_in;
  end

  // Payload holds between items
  always_ff @(posedge clk)
  begin
    if (valid_in)
      data_out <= data_in;
  end

endmodule

`default_nettype wire

//--- verilog/norm_round_top.sv
// Normalize and round unit, two register stages
// Stage 0 classifies and normalizes, stage 1 rounds and packs

`timescale 1ns/1ps
`default_nettype none

`include "norm_params.svh"

module norm_round_top
(
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  norm_pkg::op_in_t   req,
  output logic               out_valid,
  output norm_pkg::result_t  res
);

  localparam int PIPE = `NORM_PIPE_STAGES;

  norm_pkg::special_t                spec0;
  norm_pkg::norm_t                   norm0;
  norm_pkg::stage1_t                 s1_in;
  norm_pkg::stage1_t                 s1;
  logic                              s1_valid;
  logic [`NORM_EXP_W-1:0]            rnd_exp;
  logic [`NORM_MANT_W-1:0]           rnd_mant;
  logic                              rnd_nx;
  norm_pkg::result_t                 res1;

  //////////////////////////////////////////////////
  // Stage 0
  //////////////////////////////////////////////////
  special_case_sel u_special (.req(req), .spec(spec0));

  normalizer u_norm (.req(req), .norm(norm0));

  assign s1_in = '{norm: norm0, spec: spec0, fmt: req.fmt, rm: req.rm};

  stage_reg #(.payload_t(norm_pkg::stage1_t)) u_stage1
  (
    .clk      (clk),
    .rst      (rst),
    .valid_in (in_valid),
    .data_in  (s1_in),
    .valid_out(s1_valid),
    .data_out (s1)
  );

  //////////////////////////////////////////////////
  // Stage 1
  //////////////////////////////////////////////////
  rounder u_round
  (
    .norm    (s1.norm),
    .fmt     (s1.fmt),
    .rm      (s1.rm),
    .exp_out (rnd_exp),
    .mant_out(rnd_mant),
    .inexact (rnd_nx)
  );

  result_packer u_pack
  (
    .spec   (s1.spec),
    .fmt    (s1.fmt),
    .sign   (s1.norm.sign),
    .exp    (rnd_exp),
    .mant   (rnd_mant),
    .uf     (s1.norm.uf),
    .of     (s1.norm.of),
    .inexact(rnd_nx),
    .res    (res1)
  );

  stage_reg #(.payload_t(norm_pkg::result_t)) u_stage2
  (
    .clk      (clk),
    .rst      (rst),
    .valid_in (s1_valid),
    .data_in  (res1),
    .valid_out(out_valid),
    .data_out (res)
  );

  // Divide and sqrt are exclusive
  assert property (@(posedge clk) disable iff (rst)
    in_valid |-> !(req.div_en && req.sqrt_en))
    else $error("norm_round_top: div_en and sqrt_en both set");

  // Fixed latency once reset has cleared the pipe
  assert property (@(posedge clk) disable iff (rst)
    (!$past(rst, 1) && !$past(rst, PIPE)) |-> (out_valid == $past(in_valid, PIPE)))
    else $error("norm_round_top: out_valid does not follow in_valid");

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Testbench clock source
// Free running clock, first rising edge half a period after start

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
  parameter int PERIOD_NS = 100
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;                         // Low at time zero
    forever
    begin
      #(PERIOD_NS / 2);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- testbench/norm_round_tb.sv
// Testbench for the normalize and round unit
// Applies a table of requests and checks words, flags and valid timing

`timescale 1ns/1ps
`default_nettype none

`include "norm_params.svh"

module norm_round_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 8;
  localparam int ROWS       = 24;
  localparam int MAX_GAP    = 3;                        // Idle cycles between rows
  localparam int WATCHDOG_CYCLES =
    ROWS * (MAX_GAP + `NORM_PIPE_STAGES + 4) + RST_CYCLES;

  // Flag bits in NV DZ OF UF NX order
  localparam logic [4:0] F_NONE = 5'b00000;
  localparam logic [4:0] F_NX   = 5'b00001;
  localparam logic [4:0] F_UF   = 5'b00010;
  localparam logic [4:0] F_OF   = 5'b00100;
  localparam logic [4:0] F_DZ   = 5'b01000;
  localparam logic [4:0] F_NV   = 5'b10000;

  // Operand class bits from inf_a down to snan
  localparam logic [6:0] C_NONE   = 7'b0000000;
  localparam logic [6:0] C_INF_A  = 7'b1000000;
  localparam logic [6:0] C_INF_B  = 7'b0100000;
  localparam logic [6:0] C_ZERO_A = 7'b0010000;
  localparam logic [6:0] C_ZERO_B = 7'b0001000;
  localparam logic [6:0] C_NAN_A  = 7'b0000100;
  localparam logic [6:0] C_NAN_B  = 7'b0000010;
  localparam logic [6:0] C_SNAN   = 7'b0000001;

  localparam norm_pkg::fmt_e F32 = norm_pkg::FMT_FP32;
  localparam norm_pkg::fmt_e F16 = norm_pkg::FMT_FP16;
  localparam norm_pkg::rm_e  RNE = norm_pkg::RM_NEAREST;
  localparam norm_pkg::rm_e  RTZ = norm_pkg::RM_TRUNC;
  localparam norm_pkg::rm_e  RUP = norm_pkg::RM_PLUSINF;
  localparam norm_pkg::rm_e  RDN = norm_pkg::RM_MINUSINF;

  logic               clk;
  logic               rst;
  logic               in_valid;
  norm_pkg::op_in_t   req;
  logic               out_valid;
  norm_pkg::result_t  res;

  norm_pkg::op_in_t   row_req [ROWS];
  norm_pkg::result_t  row_exp [ROWS];                  // Word and flags by hand
  bit                 row_b2b [ROWS];                  // No gap before this row

  norm_pkg::result_t  exp_q [$];
  int                 row_q [$];
  norm_pkg::result_t  exp_r;
  int                 exp_row;
  int                 checked;
  logic [1:0]         valid_hist;                      // in_valid seen one and two cycles ago

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

  norm_round_top UUT
  (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .req      (req),
    .out_valid(out_valid),
    .res      (res)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // Normal quotient with no special class
  function automatic norm_pkg::op_in_t num_req(input logic [`NORM_IN_MANT_W-1:0] mant,
                                               input int exp, input bit sign,
                                               input norm_pkg::fmt_e fmt,
                                               input norm_pkg::rm_e rm);
    norm_pkg::op_in_t r;
    r        = '0;
    r.mant   = mant;
    r.exp    = exp[`NORM_IN_EXP_W-1:0];                // Biased for fmt
    r.sign   = sign;
    r.div_en = 1'b1;
    r.fmt    = fmt;
    r.rm     = rm;
    return r;
  endfunction

  // Special operand request that divides unless sqrt is set
  function automatic norm_pkg::op_in_t cls_req(input logic [6:0] cls, input bit sign,
                                               input bit sqrt, input norm_pkg::fmt_e fmt);
    norm_pkg::op_in_t r;
    r         = num_req(28'h800_0000, 127, sign, fmt, RNE);
    r.div_en  = !sqrt;
    r.sqrt_en = sqrt;
    {r.inf_a, r.inf_b, r.zero_a, r.zero_b, r.nan_a, r.nan_b, r.snan} = cls;
    return r;
  endfunction

  task automatic set_row(input int idx, input norm_pkg::op_in_t r, input logic [31:0] word,
                         input logic [4:0] flags, input bit b2b);
    row_req[idx] = r;
    row_exp[idx] = {word, flags};
    row_b2b[idx] = b2b;
  endtask

  //////////////////////////////////////////////////
  // Stimulus and expected values
  //////////////////////////////////////////////////
  task automatic load_table();
    // Exact binary32 1.x and 0.1x
    set_row(0, num_req(28'h800_0000, 127, 1'b0, F32, RNE), 32'h3F80_0000, F_NONE, 1'b0);
    set_row(1, num_req(28'h600_0000, 128, 1'b1, F32, RNE), 32'hBFC0_0000, F_NONE, 1'b1);
    // Ties to even going down then up
    set_row(2, num_req(28'h800_0008, 127, 1'b0, F32, RNE), 32'h3F80_0000, F_NX, 1'b0);
    set_row(3, num_req(28'h800_0018, 127, 1'b0, F32, RNE), 32'h3F80_0002, F_NX, 1'b1);
    set_row(4, num_req(28'h800_001F, 127, 1'b0, F32, RTZ), 32'h3F80_0001, F_NX, 1'b1);
    // Directed modes follow the sign
    set_row(5, num_req(28'h800_0001, 127, 1'b0, F32, RUP), 32'h3F80_0001, F_NX, 1'b1);
    set_row(6, num_req(28'h800_0001, 127, 1'b1, F32, RUP), 32'hBF80_0000, F_NX, 1'b0);
    set_row(7, num_req(28'h800_0001, 127, 1'b1, F32, RDN), 32'hBF80_0001, F_NX, 1'b1);
    set_row(8, num_req(28'hFFF_FFF8, 127, 1'b0, F32, RNE), 32'h4000_0000, F_NX, 1'b0);
    // binary16 rounded at bit 13 and boxed
    set_row(9, num_req(28'h800_0000, 15, 1'b0, F16, RNE), 32'hFFFF_3C00, F_NONE, 1'b0);
    set_row(10, num_req(28'h803_0000, 15, 1'b0, F16, RNE), 32'hFFFF_3C02, F_NX, 1'b1);
    set_row(11, num_req(28'h800_0010, 15, 1'b0, F16, RUP), 32'hFFFF_3C01, F_NX, 1'b1);
    // Overflow per format
    set_row(12, num_req(28'h800_0000, 31, 1'b0, F16, RNE), 32'hFFFF_7C00, F_OF, 1'b0);
    set_row(13, num_req(28'hC00_0000, 255, 1'b1, F32, RNE), 32'hFF80_0000, F_OF, 1'b1);
    // Denormals
    set_row(14, num_req(28'h800_0000, -2, 1'b0, F32, RNE), 32'h0010_0000, F_UF, 1'b0);
    set_row(15, num_req(28'h800_0030, 0, 1'b0, F32, RNE), 32'h0040_0002, F_UF | F_NX,
            1'b1);
    // Special operands
    set_row(16, cls_req(C_NAN_A, 1'b0, 1'b0, F32), 32'h7FC0_0000, F_NONE, 1'b0);
    set_row(17, cls_req(C_NAN_B | C_SNAN, 1'b0, 1'b0, F32), 32'h7FC0_0000, F_NV, 1'b1);
    set_row(18, cls_req(C_INF_A | C_INF_B, 1'b0, 1'b0, F32), 32'h7FC0_0000, F_NV, 1'b1);
    set_row(19, cls_req(C_ZERO_A | C_ZERO_B, 1'b0, 1'b0, F32), 32'h7FC0_0000,
            F_NV | F_DZ, 1'b1);
    set_row(20, cls_req(C_ZERO_B, 1'b1, 1'b0, F32), 32'hFF80_0000, F_DZ, 1'b0);
    set_row(21, cls_req(C_INF_B, 1'b1, 1'b0, F32), 32'h8000_0000, F_NONE, 1'b1);
    set_row(22, cls_req(C_NONE, 1'b1, 1'b1, F32), 32'h7FC0_0000, F_NV, 1'b0);
    set_row(23, cls_req(C_INF_A, 1'b1, 1'b1, F16), 32'hFFFF_7E00, F_NV, 1'b1);
  endtask

  initial
  begin
    int gap;
    load_table();
    void'($urandom(20));
    rst      = 1'b1;
    in_valid = 1'b0;
    req      = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < ROWS; i++)
    begin
      gap = row_b2b[i] ? 0 : 1 + int'($urandom % MAX_GAP);
      repeat (gap)
      begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
      @(posedge clk);
      in_valid <= 1'b1;
      req      <= row_req[i];
      exp_q.push_back(row_exp[i]);
      row_q.push_back(i);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    wait (checked == ROWS);
    repeat (4) @(posedge clk);                         // Room for a stray out_valid
    $display("All checks passed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Checker on the falling edge
  //////////////////////////////////////////////////
  initial
  begin
    checked    = 0;
    valid_hist = 2'b00;
  end

  always @(negedge clk)
  begin
    if (rst)
    begin
      assert (out_valid === 1'b0)
        else stop_with_error($sformatf("Error out_valid exp %h got %h", 1'b0, out_valid));
      valid_hist = 2'b00;
    end
    else
    begin
      // Two register stages between in_valid and out_valid
      assert (out_valid === valid_hist[1])
        else stop_with_error($sformatf("Error out_valid exp %h got %h",
                                       valid_hist[1], out_valid));
      if (out_valid)
      begin
        assert (exp_q.size() > 0)
          else stop_with_error("A result came out with no request pending");
        exp_r   = exp_q.pop_front();
        exp_row = row_q.pop_front();
        assert (res.word === exp_r.word)
          else stop_with_error($sformatf("Error res.word exp %h got %h in row %0d",
                                         exp_r.word, res.word, exp_row));
        assert (res.flags === exp_r.flags)
          else stop_with_error($sformatf("Error res.flags exp %h got %h in row %0d",
                                         exp_r.flags, res.flags, exp_row));
        checked++;
      end
      valid_hist = {valid_hist[0], in_valid};
    end
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_error("Timeout while waiting for results from the DUT");
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/norm_pkg.sv
verilog/special_case_sel.sv
verilog/normalizer.sv
verilog/rounder.sv
verilog/result_packer.sv
verilog/stage_reg.sv
verilog/norm_round_top.sv
testbench/tb_clock_gen.sv
testbench/norm_round_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the normalize and round testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module norm_round_tb \
  -f files.f \
  --Mdir obj_dir

./obj_dir/Vnorm_round_tb
